// File: Makefile
TOP = tb_cuckoo

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f project.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

// File: cuckoo_apb_regs.sv
`include "cuckoo_defs.svh"
`default_nettype none

module cuckoo_apb_regs (
    input  logic                         clk,
    input  logic                         __srst,
    input  cuckoo_ctrl_pkg::apb_req_t    apb_req,
    output cuckoo_ctrl_pkg::apb_rsp_t    apb_rsp,
    input  cuckoo_ctrl_pkg::cuckoo_evt_t evt,
    output logic                         enable,
    output logic [`CUCKOO_REG_WIDTH-1:0] ops_limit
);

    localparam int NUM_CNT = 4;

    typedef logic [`CUCKOO_REG_WIDTH-1:0] reg_t;

    reg_t               cnt [NUM_CNT];
    reg_t               active;
    reg_t               rdata;
    logic [NUM_CNT-1:0] evt_vec;
    logic               access;
    logic               mapped;
    logic               read_only;
    logic               wr_en;
    logic               cnt_clear;

    // Counter order follows the register map
    assign evt_vec = {evt.delete_fail, evt.delete_ok, evt.insert_fail, evt.insert_ok};

    // ------------------------------
    // Decode
    // ------------------------------
    assign access = apb_req.psel && apb_req.penable;

    always_comb begin
        mapped    = 1'b1;
        read_only = 1'b1;
        rdata     = '0;
        case (apb_req.paddr)
            `CUCKOO_ADDR_CONTROL: begin
                read_only = 1'b0;
                rdata     = reg_t'(enable);
            end
            `CUCKOO_ADDR_OPS_LIMIT: begin
                read_only = 1'b0;
                rdata     = ops_limit;
            end
            `CUCKOO_ADDR_INSERT_OK:   rdata = cnt[0];
            `CUCKOO_ADDR_INSERT_FAIL: rdata = cnt[1];
            `CUCKOO_ADDR_DELETE_OK:   rdata = cnt[2];
            `CUCKOO_ADDR_DELETE_FAIL: rdata = cnt[3];
            `CUCKOO_ADDR_ACTIVE:      rdata = active;
            default:                  mapped = 1'b0;
        endcase
    end

    assign wr_en     = access && apb_req.pwrite && mapped && !read_only;
    assign cnt_clear = wr_en && (apb_req.paddr == `CUCKOO_ADDR_CONTROL) && apb_req.pwdata[1];

    // No wait states
    assign apb_rsp.prdata  = rdata;
    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.pslverr = access && (!mapped || (apb_req.pwrite && read_only));

    // ------------------------------
    // Control
    // ------------------------------
    always_ff @(posedge clk) begin
        if (__srst) begin
            enable    <= 1'b0;
            ops_limit <= `CUCKOO_OPS_LIMIT_RESET;
        end else if (wr_en) begin
            if (apb_req.paddr == `CUCKOO_ADDR_CONTROL)   enable    <= apb_req.pwdata[0];
            if (apb_req.paddr == `CUCKOO_ADDR_OPS_LIMIT) ops_limit <= apb_req.pwdata;
        end
    end

    // ------------------------------
    // Counters
    // ------------------------------
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_CNT; i++) begin
            if (__srst || cnt_clear) cnt[i] <= '0;
            else if (evt_vec[i])     cnt[i] <= cnt[i] + 1'b1;
        end
    end

    // Fill level survives a counter clear and a table CLEAR
    always_ff @(posedge clk) begin
        if (__srst)             active <= '0;
        else if (evt.insert_ok) active <= active + 1'b1;
        else if (evt.delete_ok) active <= active - 1'b1;
    end

endmodule

`default_nettype wire

// File: cuckoo_controller.sv
`include "cuckoo_defs.svh"
`default_nettype none

module cuckoo_controller (
    input  logic                         clk,
    input  logic                         __srst,
    input  logic                         enable,
    input  logic [`CUCKOO_REG_WIDTH-1:0] ops_limit,
    input  logic                         req,
    input  cuckoo_ctrl_pkg::ctrl_req_t   ctrl_req,
    output logic                         rdy,
    output logic                         ack,
    output cuckoo_ctrl_pkg::ctrl_rsp_t   ctrl_rsp,
    output logic                         tbl_valid,
    output cuckoo_ctrl_pkg::tbl_req_t    tbl_req,
    input  logic                         tbl_ack,
    input  cuckoo_ctrl_pkg::tbl_rsp_t    tbl_rsp,
    output cuckoo_ctrl_pkg::cuckoo_evt_t evt
);

    cuckoo_ctrl_pkg::state_t      state;
    cuckoo_ctrl_pkg::state_t      nxt_state;
    cuckoo_ctrl_pkg::command_t    command;
    cuckoo_ctrl_pkg::command_t    tbl_command;
    htable_pkg::entry_t           hand;
    htable_pkg::entry_t           found_entry;
    htable_pkg::key_t             orig_key;
    htable_pkg::tbl_idx_t         tbl_idx;
    logic [`CUCKOO_REG_WIDTH-1:0] moves;
    logic                         found;
    logic                         accept;
    logic                         hit;
    logic                         evict;
    logic                         last_tbl;
    logic                         loop_limit;
    logic                         idx_inc;

    assign accept   = req && rdy;
    assign hit      = tbl_rsp.occupied && (tbl_rsp.entry.key == hand.key);
    assign evict    = (state == cuckoo_ctrl_pkg::ST_INSERT_SET_WAIT) && tbl_ack && tbl_rsp.occupied;
    assign last_tbl = (tbl_idx == htable_pkg::tbl_idx_t'(`CUCKOO_NUM_TABLES - 1));

    // Give up only with the original key in hand, so that key is the one left out
    assign loop_limit = (hand.key == orig_key) && (moves > ops_limit);

    // ------------------------------
    // FSM
    // ------------------------------
    always_ff @(posedge clk) begin
        if (__srst) begin
            state <= cuckoo_ctrl_pkg::ST_IDLE;
        end else begin
            state <= nxt_state;
        end
    end

    always_comb begin
        nxt_state   = state;
        rdy         = 1'b0;
        ack         = 1'b0;
        tbl_valid   = 1'b0;
        tbl_command = cuckoo_ctrl_pkg::COMMAND_NOP;
        idx_inc     = 1'b0;
        case (state)
            cuckoo_ctrl_pkg::ST_IDLE: begin
                rdy = enable;
                if (req && enable) begin
                    case (ctrl_req.command)
                        cuckoo_ctrl_pkg::COMMAND_NOP:   nxt_state = cuckoo_ctrl_pkg::ST_DONE;
                        cuckoo_ctrl_pkg::COMMAND_CLEAR: nxt_state = cuckoo_ctrl_pkg::ST_CLEAR;
                        cuckoo_ctrl_pkg::COMMAND_GET,
                        cuckoo_ctrl_pkg::COMMAND_SET,
                        cuckoo_ctrl_pkg::COMMAND_UNSET: nxt_state = cuckoo_ctrl_pkg::ST_CHECK;
                        default:                        nxt_state = cuckoo_ctrl_pkg::ST_ERROR;
                    endcase
                end
            end
            // Lookup over all tables
            cuckoo_ctrl_pkg::ST_CHECK: begin
                tbl_valid   = 1'b1;
                tbl_command = cuckoo_ctrl_pkg::COMMAND_GET;
                nxt_state   = cuckoo_ctrl_pkg::ST_CHECK_WAIT;
            end
            cuckoo_ctrl_pkg::ST_CHECK_WAIT: begin
                if (tbl_ack) begin
                    if (hit) begin
                        if (command == cuckoo_ctrl_pkg::COMMAND_GET) begin
                            nxt_state = cuckoo_ctrl_pkg::ST_DONE;
                        end else if (command == cuckoo_ctrl_pkg::COMMAND_UNSET) begin
                            nxt_state = cuckoo_ctrl_pkg::ST_DELETE;
                        end else begin
                            nxt_state = cuckoo_ctrl_pkg::ST_ERROR;
                        end
                    end else begin
                        // Wraps back to table 0 after the last one, ready for an insert
                        idx_inc = 1'b1;
                        if (!last_tbl) begin
                            nxt_state = cuckoo_ctrl_pkg::ST_CHECK;
                        end else if (command == cuckoo_ctrl_pkg::COMMAND_GET) begin
                            nxt_state = cuckoo_ctrl_pkg::ST_DONE;
                        end else if (command == cuckoo_ctrl_pkg::COMMAND_SET) begin
                            nxt_state = cuckoo_ctrl_pkg::ST_INSERT_GET;
                        end else begin
                            nxt_state = cuckoo_ctrl_pkg::ST_ERROR;
                        end
                    end
                end
            end
            cuckoo_ctrl_pkg::ST_DELETE: begin
                tbl_valid   = 1'b1;
                tbl_command = cuckoo_ctrl_pkg::COMMAND_UNSET;
                nxt_state   = cuckoo_ctrl_pkg::ST_DELETE_WAIT;
            end
            cuckoo_ctrl_pkg::ST_DELETE_WAIT: begin
                if (tbl_ack) nxt_state = cuckoo_ctrl_pkg::ST_DONE;
            end
            cuckoo_ctrl_pkg::ST_CLEAR: begin
                tbl_valid   = 1'b1;
                tbl_command = cuckoo_ctrl_pkg::COMMAND_CLEAR;
                nxt_state   = cuckoo_ctrl_pkg::ST_CLEAR_WAIT;
            end
            cuckoo_ctrl_pkg::ST_CLEAR_WAIT: begin
                if (tbl_ack) begin
                    idx_inc   = 1'b1;
                    nxt_state = last_tbl ? cuckoo_ctrl_pkg::ST_DONE : cuckoo_ctrl_pkg::ST_CLEAR;
                end
            end
            // Displacement loop
            cuckoo_ctrl_pkg::ST_INSERT_GET: begin
                tbl_valid   = 1'b1;
                tbl_command = cuckoo_ctrl_pkg::COMMAND_GET;
                nxt_state   = cuckoo_ctrl_pkg::ST_INSERT_GET_WAIT;
            end
            cuckoo_ctrl_pkg::ST_INSERT_GET_WAIT: begin
                if (tbl_ack) begin
                    if (tbl_rsp.occupied && loop_limit) begin
                        nxt_state = cuckoo_ctrl_pkg::ST_ERROR;
                    end else begin
                        nxt_state = cuckoo_ctrl_pkg::ST_INSERT_SET;
                    end
                end
            end
            cuckoo_ctrl_pkg::ST_INSERT_SET: begin
                tbl_valid   = 1'b1;
                tbl_command = cuckoo_ctrl_pkg::COMMAND_SET;
                nxt_state   = cuckoo_ctrl_pkg::ST_INSERT_SET_WAIT;
            end
            cuckoo_ctrl_pkg::ST_INSERT_SET_WAIT: begin
                if (tbl_ack) begin
                    idx_inc   = tbl_rsp.occupied;
                    nxt_state = tbl_rsp.occupied ? cuckoo_ctrl_pkg::ST_INSERT_GET
                                                 : cuckoo_ctrl_pkg::ST_DONE;
                end
            end
            cuckoo_ctrl_pkg::ST_DONE,
            cuckoo_ctrl_pkg::ST_ERROR: begin
                ack       = 1'b1;
                nxt_state = cuckoo_ctrl_pkg::ST_IDLE;
            end
            default: nxt_state = cuckoo_ctrl_pkg::ST_IDLE;
        endcase
    end

    // ------------------------------
    // Context
    // ------------------------------
    // Request entry, then whichever entry was last pushed out
    always_ff @(posedge clk) begin
        if (accept) begin
            command    <= ctrl_req.command;
            orig_key   <= ctrl_req.key;
            hand.key   <= ctrl_req.key;
            hand.value <= ctrl_req.value;
        end else if (evict) begin
            hand <= tbl_rsp.entry;
        end
    end

    always_ff @(posedge clk) begin
        if (state == cuckoo_ctrl_pkg::ST_IDLE) begin
            tbl_idx <= '0;
            moves   <= '0;
        end else begin
            if (idx_inc) tbl_idx <= last_tbl ? '0 : tbl_idx + 1'b1;
            if (evict)   moves   <= moves + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (__srst || accept) begin
            found <= 1'b0;
        end else if ((state == cuckoo_ctrl_pkg::ST_CHECK_WAIT) && tbl_ack && hit) begin
            found       <= 1'b1;
            found_entry <= tbl_rsp.entry;
        end
    end

    assign tbl_req.command = tbl_command;
    assign tbl_req.tbl_idx = tbl_idx;
    assign tbl_req.entry   = hand;

    // ------------------------------
    // Response and outcomes
    // ------------------------------
    assign ctrl_rsp.status = (state == cuckoo_ctrl_pkg::ST_DONE) ? cuckoo_ctrl_pkg::STATUS_OK
                                                                  : cuckoo_ctrl_pkg::STATUS_ERROR;
    assign ctrl_rsp.found  = found;
    assign ctrl_rsp.key    = found ? found_entry.key : '0;
    assign ctrl_rsp.value  = found ? found_entry.value : '0;

    always_ff @(posedge clk) begin
        if (__srst) begin
            evt <= '0;
        end else begin
            evt.insert_ok   <= ack && !ctrl_rsp.status && (command == cuckoo_ctrl_pkg::COMMAND_SET);
            evt.insert_fail <= ack && ctrl_rsp.status && (command == cuckoo_ctrl_pkg::COMMAND_SET);
            evt.delete_ok   <= ack && !ctrl_rsp.status && (command == cuckoo_ctrl_pkg::COMMAND_UNSET);
            evt.delete_fail <= ack && ctrl_rsp.status && (command == cuckoo_ctrl_pkg::COMMAND_UNSET);
        end
    end

endmodule

`default_nettype wire

// File: cuckoo_ctrl_pkg.sv
`include "cuckoo_defs.svh"
`default_nettype none

package cuckoo_ctrl_pkg;

    // ------------------------------
    // Encodings
    // ------------------------------
    typedef enum logic [2:0] {
        COMMAND_NOP   = 3'd0,
        COMMAND_GET   = 3'd1,
        COMMAND_SET   = 3'd2,
        COMMAND_UNSET = 3'd3,
        COMMAND_CLEAR = 3'd4
    } command_t;

    typedef enum logic {
        STATUS_OK    = 1'b0,
        STATUS_ERROR = 1'b1
    } status_t;

    // Controller FSM
    typedef enum logic [3:0] {
        ST_IDLE,
        ST_CHECK,
        ST_CHECK_WAIT,
        ST_DELETE,
        ST_DELETE_WAIT,
        ST_CLEAR,
        ST_CLEAR_WAIT,
        ST_INSERT_GET,
        ST_INSERT_GET_WAIT,
        ST_INSERT_SET,
        ST_INSERT_SET_WAIT,
        ST_DONE,
        ST_ERROR
    } state_t;

    // ------------------------------
    // Request port
    // ------------------------------
    typedef struct packed {
        command_t           command;
        htable_pkg::key_t   key;
        htable_pkg::value_t value;
    } ctrl_req_t;

    typedef struct packed {
        status_t            status;
        logic               found;
        htable_pkg::key_t   key;
        htable_pkg::value_t value;
    } ctrl_rsp_t;

    // ------------------------------
    // Table bank access
    // ------------------------------
    typedef struct packed {
        command_t             command;
        htable_pkg::tbl_idx_t tbl_idx;
        htable_pkg::entry_t   entry;
    } tbl_req_t;

    typedef struct packed {
        logic               occupied;
        htable_pkg::entry_t entry;
    } tbl_rsp_t;

    // Outcome pulses toward the counters
    typedef struct packed {
        logic insert_ok;
        logic insert_fail;
        logic delete_ok;
        logic delete_fail;
    } cuckoo_evt_t;

    // ------------------------------
    // APB
    // ------------------------------
    typedef struct packed {
        logic                              psel;
        logic                              penable;
        logic                              pwrite;
        logic [`CUCKOO_APB_ADDR_WIDTH-1:0] paddr;
        logic [`CUCKOO_REG_WIDTH-1:0]      pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [`CUCKOO_REG_WIDTH-1:0] prdata;
        logic                         pready;
        logic                         pslverr;
    } apb_rsp_t;

endpackage

`default_nettype wire

// File: cuckoo_defs.svh
`ifndef CUCKOO_DEFS_SVH
`define CUCKOO_DEFS_SVH

// Entry and table geometry
`define CUCKOO_KEY_WIDTH        16
`define CUCKOO_VALUE_WIDTH      16
`define CUCKOO_NUM_TABLES       2
`define CUCKOO_SLOT_WIDTH       4

// Register file
`define CUCKOO_APB_ADDR_WIDTH   8
`define CUCKOO_REG_WIDTH        32
`define CUCKOO_OPS_LIMIT_RESET  8

// Register byte offsets
`define CUCKOO_ADDR_CONTROL     8'h00
`define CUCKOO_ADDR_OPS_LIMIT   8'h04
`define CUCKOO_ADDR_INSERT_OK   8'h08
`define CUCKOO_ADDR_INSERT_FAIL 8'h0C
`define CUCKOO_ADDR_DELETE_OK   8'h10
`define CUCKOO_ADDR_DELETE_FAIL 8'h14
`define CUCKOO_ADDR_ACTIVE      8'h18

`endif

// File: cuckoo_table_bank.sv
`include "cuckoo_defs.svh"
`default_nettype none

module cuckoo_table_bank (
    input  logic                      clk,
    input  logic                      __srst,
    input  logic                      tbl_valid,
    input  cuckoo_ctrl_pkg::tbl_req_t tbl_req,
    output logic                      tbl_ack,
    output cuckoo_ctrl_pkg::tbl_rsp_t tbl_rsp
);

    localparam int NUM_SLOTS = 1 << `CUCKOO_SLOT_WIDTH;

    htable_pkg::entry_t   mem   [`CUCKOO_NUM_TABLES][NUM_SLOTS];
    logic [NUM_SLOTS-1:0] valid [`CUCKOO_NUM_TABLES];

    htable_pkg::slot_t    slot;
    htable_pkg::tbl_idx_t idx;

    // ------------------------------
    // Hash
    // ------------------------------
    // Table n takes key nibble n as its slot
    assign idx  = tbl_req.tbl_idx;
    assign slot = tbl_req.entry.key[idx * `CUCKOO_SLOT_WIDTH +: `CUCKOO_SLOT_WIDTH];

    // ------------------------------
    // Storage
    // ------------------------------
    always_ff @(posedge clk) begin
        if (tbl_valid && (tbl_req.command == cuckoo_ctrl_pkg::COMMAND_SET)) begin
            mem[idx][slot] <= tbl_req.entry;
        end
    end

    always_ff @(posedge clk) begin
        if (__srst) begin
            for (int t = 0; t < `CUCKOO_NUM_TABLES; t++) begin
                valid[t] <= '0;
            end
        end else if (tbl_valid) begin
            case (tbl_req.command)
                cuckoo_ctrl_pkg::COMMAND_SET:   valid[idx][slot] <= 1'b1;
                cuckoo_ctrl_pkg::COMMAND_UNSET: valid[idx][slot] <= 1'b0;
                cuckoo_ctrl_pkg::COMMAND_CLEAR: valid[idx]       <= '0;
                default: ;
            endcase
        end
    end

    // ------------------------------
    // Response
    // ------------------------------
    always_ff @(posedge clk) begin
        if (__srst) begin
            tbl_ack <= 1'b0;
        end else begin
            tbl_ack <= tbl_valid;
        end
    end

    // Slot contents before this access, so SET and UNSET hand back the old entry
    always_ff @(posedge clk) begin
        if (tbl_valid) begin
            tbl_rsp.occupied <= valid[idx][slot];
            tbl_rsp.entry    <= mem[idx][slot];
        end
    end

endmodule

`default_nettype wire

// File: cuckoo_top.sv
`include "cuckoo_defs.svh"
`default_nettype none

module cuckoo_top (
    input  logic                       clk,
    input  logic                       __srst,
    input  cuckoo_ctrl_pkg::apb_req_t  apb_req,
    output cuckoo_ctrl_pkg::apb_rsp_t  apb_rsp,
    input  logic                       req,
    input  cuckoo_ctrl_pkg::ctrl_req_t ctrl_req,
    output logic                       rdy,
    output logic                       ack,
    output cuckoo_ctrl_pkg::ctrl_rsp_t ctrl_rsp
);

    logic                         enable;
    logic [`CUCKOO_REG_WIDTH-1:0] ops_limit;
    cuckoo_ctrl_pkg::cuckoo_evt_t evt;
    logic                         tbl_valid;
    logic                         tbl_ack;
    cuckoo_ctrl_pkg::tbl_req_t    tbl_req;
    cuckoo_ctrl_pkg::tbl_rsp_t    tbl_rsp;

    cuckoo_controller i_cuckoo_controller (
        .clk       ( clk ),
        .__srst    ( __srst ),
        .enable    ( enable ),
        .ops_limit ( ops_limit ),
        .req       ( req ),
        .ctrl_req  ( ctrl_req ),
        .rdy       ( rdy ),
        .ack       ( ack ),
        .ctrl_rsp  ( ctrl_rsp ),
        .tbl_valid ( tbl_valid ),
        .tbl_req   ( tbl_req ),
        .tbl_ack   ( tbl_ack ),
        .tbl_rsp   ( tbl_rsp ),
        .evt       ( evt )
    );

    cuckoo_table_bank i_cuckoo_table_bank (
        .clk       ( clk ),
        .__srst    ( __srst ),
        .tbl_valid ( tbl_valid ),
        .tbl_req   ( tbl_req ),
        .tbl_ack   ( tbl_ack ),
        .tbl_rsp   ( tbl_rsp )
    );

    cuckoo_apb_regs i_cuckoo_apb_regs (
        .clk       ( clk ),
        .__srst    ( __srst ),
        .apb_req   ( apb_req ),
        .apb_rsp   ( apb_rsp ),
        .evt       ( evt ),
        .enable    ( enable ),
        .ops_limit ( ops_limit )
    );

endmodule

`default_nettype wire

// File: htable_pkg.sv
`include "cuckoo_defs.svh"
`default_nettype none

package htable_pkg;

    // ------------------------------
    // Stored data
    // ------------------------------
    typedef logic [`CUCKOO_KEY_WIDTH-1:0]   key_t;
    typedef logic [`CUCKOO_VALUE_WIDTH-1:0] value_t;

    // One table slot as stored and as moved between tables
    typedef struct packed {
        key_t   key;
        value_t value;
    } entry_t;

    // ------------------------------
    // Addressing
    // ------------------------------
    typedef logic [`CUCKOO_SLOT_WIDTH-1:0]         slot_t;
    typedef logic [$clog2(`CUCKOO_NUM_TABLES)-1:0] tbl_idx_t;

endpackage

`default_nettype wire

// File: project.f
+incdir+.
htable_pkg.sv
cuckoo_ctrl_pkg.sv
cuckoo_table_bank.sv
cuckoo_controller.sv
cuckoo_apb_regs.sv
cuckoo_top.sv
tb_cuckoo.sv

// File: tb_cuckoo.sv
`include "cuckoo_defs.svh"
`default_nettype none

module tb_cuckoo;

    logic                       clk;
    logic                       __srst;
    cuckoo_ctrl_pkg::apb_req_t  apb_req;
    cuckoo_ctrl_pkg::apb_rsp_t  apb_rsp;
    logic                       req;
    cuckoo_ctrl_pkg::ctrl_req_t ctrl_req;
    logic                       rdy;
    logic                       ack;
    cuckoo_ctrl_pkg::ctrl_rsp_t ctrl_rsp;

    cuckoo_ctrl_pkg::ctrl_rsp_t last_rsp;
    htable_pkg::key_t           used_keys [$];
    htable_pkg::key_t           stored_keys [$];
    htable_pkg::value_t         stored_vals [$];
    integer                     seed;
    int                         errors;
    int                         ins_ok;
    int                         ins_fail;
    int                         del_ok;
    int                         del_fail;

    cuckoo_top UUT (
        .clk      ( clk ),
        .__srst   ( __srst ),
        .apb_req  ( apb_req ),
        .apb_rsp  ( apb_rsp ),
        .req      ( req ),
        .ctrl_req ( ctrl_req ),
        .rdy      ( rdy ),
        .ack      ( ack ),
        .ctrl_rsp ( ctrl_rsp )
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b1;
        apb_req.paddr   = addr;
        apb_req.pwdata  = data;
        @(negedge clk);
        apb_req.penable = 1'b1;
        @(negedge clk);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic slverr);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
        apb_req.paddr   = addr;
        @(negedge clk);
        apb_req.penable = 1'b1;
        // Access phase ends at this edge
        @(posedge clk);
        data   = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        compare("apb_rsp.pready", apb_rsp.pready, 1'b1);
        @(negedge clk);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic read_expect(input logic [7:0] addr, input string name,
                               input logic [31:0] exp);
        logic [31:0] data;
        logic        slverr;
        apb_read(addr, data, slverr);
        compare(name, data, exp);
        compare({name, " pslverr"}, slverr, 1'b0);
    endtask

    task automatic do_request(input cuckoo_ctrl_pkg::command_t cmd, input htable_pkg::key_t key,
                              input htable_pkg::value_t value);
        int n;
        n                = 0;
        ctrl_req.command = cmd;
        ctrl_req.key     = key;
        ctrl_req.value   = value;
        req              = 1'b1;
        while (!rdy && n < 200) begin
            @(negedge clk);
            n++;
        end
        if (!rdy) begin
            errors++;
            $display("Request at %0t was never accepted, rdy stayed low", $time);
            req      = 1'b0;
            last_rsp = '0;
        end else begin
            @(negedge clk);
            req = 1'b0;
            n   = 0;
            while (!ack && n < 200) begin
                @(negedge clk);
                n++;
            end
            if (!ack) begin
                errors++;
                $display("Request at %0t got no ack within 200 cycles", $time);
            end
            last_rsp = ctrl_rsp;
        end
    endtask

    // Keys in use never share a nibble, so random keys never collide
    task automatic draw_key(output htable_pkg::key_t key);
        logic clash;
        clash = 1'b1;
        for (int tries = 0; tries < 1000 && clash; tries++) begin
            key   = htable_pkg::key_t'($random(seed));
            clash = 1'b0;
            foreach (used_keys[i]) begin
                if (used_keys[i][3:0] == key[3:0] || used_keys[i][7:4] == key[7:4]) clash = 1'b1;
            end
        end
        if (clash) begin
            errors++;
            $display("Could not draw a key that avoids the keys already in use");
        end
        used_keys.push_back(key);
    endtask

    // Found, key and value are only checked for GET
    task automatic request_check(input cuckoo_ctrl_pkg::command_t cmd,
                                 input htable_pkg::key_t key, input htable_pkg::value_t value,
                                 input logic exp_error, input logic exp_found);
        do_request(cmd, key, value);
        compare("ctrl_rsp.status", last_rsp.status, exp_error);
        if (cmd == cuckoo_ctrl_pkg::COMMAND_GET) begin
            compare("ctrl_rsp.found", last_rsp.found, exp_found);
            if (exp_found) begin
                compare("ctrl_rsp.key", last_rsp.key, key);
                compare("ctrl_rsp.value", last_rsp.value, value);
            end
        end
        if (cmd == cuckoo_ctrl_pkg::COMMAND_SET) begin
            if (exp_error) ins_fail++;
            else ins_ok++;
        end
        if (cmd == cuckoo_ctrl_pkg::COMMAND_UNSET) begin
            if (exp_error) del_fail++;
            else del_ok++;
        end
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------
    task automatic register_access();
        logic [31:0] data;
        logic        slverr;
        read_expect(`CUCKOO_ADDR_CONTROL, "control", 32'd0);
        read_expect(`CUCKOO_ADDR_OPS_LIMIT, "ops_limit", 32'd8);
        // Disabled block must not take a request
        ctrl_req.command = cuckoo_ctrl_pkg::COMMAND_NOP;
        req              = 1'b1;
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            compare("rdy", rdy, 1'b0);
            compare("ack", ack, 1'b0);
        end
        req = 1'b0;
        apb_write(`CUCKOO_ADDR_OPS_LIMIT, 32'd4);
        read_expect(`CUCKOO_ADDR_OPS_LIMIT, "ops_limit", 32'd4);
        apb_read(8'h40, data, slverr);
        compare("pslverr", slverr, 1'b1);
    endtask

    task automatic basic_set_get();
        htable_pkg::key_t   key;
        htable_pkg::value_t value;
        apb_write(`CUCKOO_ADDR_CONTROL, 32'd1);
        for (int i = 0; i < 4; i++) begin
            draw_key(key);
            value = htable_pkg::value_t'($random(seed));
            request_check(cuckoo_ctrl_pkg::COMMAND_SET, key, value, 1'b0, 1'b0);
            stored_keys.push_back(key);
            stored_vals.push_back(value);
        end
        foreach (stored_keys[i]) begin
            request_check(cuckoo_ctrl_pkg::COMMAND_GET, stored_keys[i], stored_vals[i], 1'b0, 1'b1);
        end
        draw_key(key);
        request_check(cuckoo_ctrl_pkg::COMMAND_GET, key, '0, 1'b0, 1'b0);
    endtask

    task automatic error_outcomes();
        htable_pkg::key_t key;
        request_check(cuckoo_ctrl_pkg::COMMAND_SET, stored_keys[0], stored_vals[0], 1'b1, 1'b0);
        draw_key(key);
        request_check(cuckoo_ctrl_pkg::COMMAND_UNSET, key, '0, 1'b1, 1'b0);
        key = stored_keys[1];
        request_check(cuckoo_ctrl_pkg::COMMAND_UNSET, key, '0, 1'b0, 1'b0);
        request_check(cuckoo_ctrl_pkg::COMMAND_GET, key, '0, 1'b0, 1'b0);
        stored_keys.delete(1);
        stored_vals.delete(1);
    endtask

    // A and B share bits 7:0 and so both slots
    task automatic displacement();
        request_check(cuckoo_ctrl_pkg::COMMAND_SET, 16'h12FF, 16'hA1A1, 1'b0, 1'b0);
        request_check(cuckoo_ctrl_pkg::COMMAND_SET, 16'h34FF, 16'hB2B2, 1'b0, 1'b0);
        request_check(cuckoo_ctrl_pkg::COMMAND_GET, 16'h12FF, 16'hA1A1, 1'b0, 1'b1);
        request_check(cuckoo_ctrl_pkg::COMMAND_GET, 16'h34FF, 16'hB2B2, 1'b0, 1'b1);
        stored_keys.push_back(16'h12FF);
        stored_vals.push_back(16'hA1A1);
        stored_keys.push_back(16'h34FF);
        stored_vals.push_back(16'hB2B2);
    endtask

    // Third key in the same two slots can only cycle
    task automatic move_limit();
        apb_write(`CUCKOO_ADDR_OPS_LIMIT, 32'd4);
        request_check(cuckoo_ctrl_pkg::COMMAND_SET, 16'h56FF, 16'hC3C3, 1'b1, 1'b0);
        request_check(cuckoo_ctrl_pkg::COMMAND_GET, 16'h12FF, 16'hA1A1, 1'b0, 1'b1);
        request_check(cuckoo_ctrl_pkg::COMMAND_GET, 16'h34FF, 16'hB2B2, 1'b0, 1'b1);
        request_check(cuckoo_ctrl_pkg::COMMAND_GET, 16'h56FF, '0, 1'b0, 1'b0);
    endtask

    task automatic counters_and_clear();
        read_expect(`CUCKOO_ADDR_INSERT_OK, "insert_ok", ins_ok);
        read_expect(`CUCKOO_ADDR_INSERT_FAIL, "insert_fail", ins_fail);
        read_expect(`CUCKOO_ADDR_DELETE_OK, "delete_ok", del_ok);
        read_expect(`CUCKOO_ADDR_DELETE_FAIL, "delete_fail", del_fail);
        read_expect(`CUCKOO_ADDR_ACTIVE, "active", ins_ok - del_ok);
        request_check(cuckoo_ctrl_pkg::COMMAND_CLEAR, '0, '0, 1'b0, 1'b0);
        foreach (stored_keys[i]) begin
            request_check(cuckoo_ctrl_pkg::COMMAND_GET, stored_keys[i], '0, 1'b0, 1'b0);
        end
        read_expect(`CUCKOO_ADDR_ACTIVE, "active", ins_ok - del_ok);
        // Counter clear with enable kept on
        apb_write(`CUCKOO_ADDR_CONTROL, 32'd3);
        read_expect(`CUCKOO_ADDR_CONTROL, "control", 32'd1);
        read_expect(`CUCKOO_ADDR_INSERT_OK, "insert_ok", 32'd0);
        read_expect(`CUCKOO_ADDR_INSERT_FAIL, "insert_fail", 32'd0);
        read_expect(`CUCKOO_ADDR_DELETE_OK, "delete_ok", 32'd0);
        read_expect(`CUCKOO_ADDR_DELETE_FAIL, "delete_fail", 32'd0);
        read_expect(`CUCKOO_ADDR_ACTIVE, "active", ins_ok - del_ok);
    endtask

    // ------------------------------
    // Sequence
    // ------------------------------
    initial begin
        seed     = 32'he20d_8cb1;
        errors   = 0;
        ins_ok   = 0;
        ins_fail = 0;
        del_ok   = 0;
        del_fail = 0;
        __srst   = 1'b1;
        req      = 1'b0;
        ctrl_req = '0;
        apb_req  = '0;
        // Reserve the nibbles of the colliding keys
        used_keys.push_back(16'h12FF);
        repeat (8) @(posedge clk);
        @(negedge clk);
        __srst = 1'b0;
        @(negedge clk);
        register_access();
        basic_set_get();
        error_outcomes();
        displacement();
        move_limit();
        counters_and_clear();
        $display("Run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
